// File: bresenham_stepper.sv
`timescale 1ns/100ps
`default_nettype none

`include "raster_defs.svh"

module bresenham_stepper import raster_pkg::*; (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 empty,
	input  wire                 rd_kind,
	input  fifo_entry_u         rd_entry,
	input  wire                 frame_ready,
	output logic                rd_en,
	output logic                pix_valid,
	output logic [`COORD_W-1:0] pix_a,
	output logic [`COORD_W-1:0] pix_b,
	output logic                pix_steep,
	output logic [`COLOR_W-1:0] pix_color,
	output logic                raster_done
);

	// Idle when low, drawing the loaded line when high
	logic                       drawing;
	line_rec_t                  cur;
	logic [`COORD_W-1:0]        a, b;
	logic signed [`COORD_W+1:0] err;
	logic signed [`COORD_W+1:0] err_sub;

	assign rd_en     = !drawing && !empty;
	assign pix_valid = drawing;
	assign pix_a     = a;
	assign pix_b     = b;
	assign pix_steep = cur.steep;
	assign pix_color = cur.color;

	assign err_sub = err - $signed({1'b0, cur.d_min});

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			drawing     <= 1'b0;
			raster_done <= 1'b0;
			cur         <= '0;
			a           <= '0;
			b           <= '0;
			err         <= '0;
		end
		else
		begin
			raster_done <= 1'b0;
			if (rd_en)
			begin
				if (rd_kind == KIND_CTRL)
					raster_done <= rd_entry.ctrl_view.eoo;
				else
				begin
					cur     <= rd_entry.line_view;
					a       <= rd_entry.line_view.a0;
					b       <= rd_entry.line_view.b0;
					err     <= $signed({1'b0, rd_entry.line_view.d_maj >> 1});
					drawing <= 1'b1;
				end
			end
			else if (drawing && frame_ready)
			begin
				// Pixel taken by the frame buffer, move to the next one
				if (a == cur.a1)
					drawing <= 1'b0;
				else
				begin
					a <= a + 1'b1;
					if (err_sub < 0)
					begin
						b   <= cur.y_neg ? b - 1'b1 : b + 1'b1;
						err <= err_sub + $signed({1'b0, cur.d_maj});
					end
					else
						err <= err_sub;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: line_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "raster_defs.svh"

module line_fifo import raster_pkg::*; (
	input  wire          clk,
	input  wire          rst,
	input  wire          wr_en,
	input  wire          wr_kind,
	input  fifo_entry_u  wr_entry,
	input  wire          rd_en,
	output logic         rd_kind,
	output fifo_entry_u  rd_entry,
	output logic         empty,
	output logic         full
);

	localparam int AW = $clog2(`LINE_FIFO_DEPTH);

	fifo_entry_u entry_mem [`LINE_FIFO_DEPTH];
	logic        kind_mem  [`LINE_FIFO_DEPTH];

	// Extra pointer bit tells full from empty
	logic [AW:0] wr_ptr, rd_ptr;

	assign empty = wr_ptr == rd_ptr;
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	// Head entry visible without a read strobe
	assign rd_entry = entry_mem[rd_ptr[AW-1:0]];
	assign rd_kind  = kind_mem[rd_ptr[AW-1:0]];

	always_ff @(posedge clk)
	begin
		if (wr_en && !full)
		begin
			entry_mem[wr_ptr[AW-1:0]] <= wr_entry;
			kind_mem[wr_ptr[AW-1:0]]  <= wr_kind;
		end
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (wr_en && !full)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en && !empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: octant_normalizer.sv
`timescale 1ns/100ps
`default_nettype none

`include "raster_defs.svh"

module octant_normalizer import raster_pkg::*; (
	input  wire                clk,
	input  wire                rst,
	input  wire                rec_valid,
	input  wire                rec_eoo,
	input  wire [`COORD_W-1:0] rx0,
	input  wire [`COORD_W-1:0] ry0,
	input  wire [`COORD_W-1:0] rx1,
	input  wire [`COORD_W-1:0] ry1,
	input  wire [`COLOR_W-1:0] rcolor,
	output logic               wr_en,
	output logic               wr_kind,
	output fifo_entry_u        wr_entry
);

	logic [`COORD_W-1:0] dx_abs, dy_abs;
	logic                steep;
	logic [`COORD_W-1:0] pa0, pb0, pa1, pb1;
	logic [`COORD_W-1:0] sa, sb, ea, eb;
	logic                y_neg;
	fifo_entry_u         next_entry;

	always_comb
	begin
		dx_abs = (rx1 >= rx0) ? rx1 - rx0 : rx0 - rx1;
		dy_abs = (ry1 >= ry0) ? ry1 - ry0 : ry0 - ry1;
		steep  = dy_abs > dx_abs;

		// Major axis first
		{pa0, pb0} = axis_swap(steep, rx0, ry0);
		{pa1, pb1} = axis_swap(steep, rx1, ry1);

		// Walk the major axis upwards
		if (pa0 > pa1)
		begin
			{sa, sb} = {pa1, pb1};
			{ea, eb} = {pa0, pb0};
		end
		else
		begin
			{sa, sb} = {pa0, pb0};
			{ea, eb} = {pa1, pb1};
		end
		y_neg = eb < sb;

		next_entry = '0;
		if (rec_eoo)
			next_entry.ctrl_view.eoo = 1'b1;
		else
		begin
			next_entry.line_view.a0    = sa;
			next_entry.line_view.b0    = sb;
			next_entry.line_view.a1    = ea;
			next_entry.line_view.d_maj = {1'b0, ea} - {1'b0, sa};
			next_entry.line_view.d_min = y_neg ? {1'b0, sb} - {1'b0, eb}
				: {1'b0, eb} - {1'b0, sb};
			next_entry.line_view.steep = steep;
			next_entry.line_view.y_neg = y_neg;
			next_entry.line_view.color = rcolor;
		end
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			wr_en   <= 1'b0;
			wr_kind <= KIND_LINE;
		end
		else
		begin
			wr_en   <= rec_valid | rec_eoo;
			wr_kind <= rec_eoo ? KIND_CTRL : KIND_LINE;
		end
	end

	always_ff @(posedge clk)
	begin
		wr_entry <= next_entry;
	end

endmodule

`default_nettype wire

// File: pixel_denormalizer.sv
`timescale 1ns/100ps
`default_nettype none

`include "raster_defs.svh"

module pixel_denormalizer import raster_pkg::*; (
	input  wire                  pix_valid,
	input  wire [`COORD_W-1:0]   pix_a,
	input  wire [`COORD_W-1:0]   pix_b,
	input  wire                  pix_steep,
	input  wire [`COLOR_W-1:0]   pix_color,
	output logic                 pixel_valid,
	output logic [`COORD_W-1:0]  frame_x,
	output logic [`FRAME_Y_W-1:0] frame_y,
	output logic [`COLOR_W-1:0]  px_color
);

	logic [`COORD_W-1:0] full_y;

	// Steep lines were drawn with a as y
	assign {frame_x, full_y} = axis_swap(pix_steep, pix_a, pix_b);

	// Rows fit in 9 bits
	assign frame_y = full_y[`FRAME_Y_W-1:0];

	assign pixel_valid = pix_valid;
	assign px_color    = pix_color;

endmodule

`default_nettype wire

// File: raster_defs.svh
`ifndef RASTER_DEFS_SVH
`define RASTER_DEFS_SVH

// Input coordinate width, wide enough for 640 columns
`define COORD_W 10

// Frame y output width, 480 rows
`define FRAME_Y_W 9

// Pixel color width
`define COLOR_W 3

// Line FIFO entries, power of two
`define LINE_FIFO_DEPTH 8

`endif

// File: raster_input_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "raster_defs.svh"

module raster_input_stage import raster_pkg::*; (
	input  wire                clk,
	input  wire                rst,
	input  wire [`COORD_W-1:0] x0_in,
	input  wire [`COORD_W-1:0] y0_in,
	input  wire [`COORD_W-1:0] x1_in,
	input  wire [`COORD_W-1:0] y1_in,
	input  wire                valid,
	input  wire                eoo,
	input  wire                obj_change,
	input  wire [`COLOR_W-1:0] bk_color,
	output logic               rec_valid,
	output logic               rec_eoo,
	output logic [`COORD_W-1:0] rx0,
	output logic [`COORD_W-1:0] ry0,
	output logic [`COORD_W-1:0] rx1,
	output logic [`COORD_W-1:0] ry1,
	output logic [`COLOR_W-1:0] rcolor
);

	// Color for lines arriving from now on
	logic [`COLOR_W-1:0] cur_color;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			rec_valid <= 1'b0;
			rec_eoo   <= 1'b0;
			cur_color <= DEFAULT_COLOR;
		end
		else
		begin
			rec_valid <= valid;
			rec_eoo   <= eoo;
			if (obj_change)
				cur_color <= bk_color;
		end
	end

	// Endpoint record, a line captured together with the color in force
	always_ff @(posedge clk)
	begin
		if (valid)
		begin
			rx0    <= x0_in;
			ry0    <= y0_in;
			rx1    <= x1_in;
			ry1    <= y1_in;
			rcolor <= cur_color;
		end
	end

endmodule

`default_nettype wire

// File: raster_pkg.sv
`default_nettype none

`include "raster_defs.svh"

package raster_pkg;

	// One normalized line, a is the major axis and b the minor axis
	typedef struct packed {
		logic [`COORD_W-1:0] a0;
		logic [`COORD_W-1:0] b0;
		logic [`COORD_W-1:0] a1;
		logic [`COORD_W:0]   d_maj;
		logic [`COORD_W:0]   d_min;
		logic                steep;
		logic                y_neg;
		logic [`COLOR_W-1:0] color;
	} line_rec_t;

	localparam int LINE_REC_W = $bits(line_rec_t);

	// Marker entry padded out to the line record width
	typedef struct packed {
		logic                  eoo;
		logic [LINE_REC_W-2:0] pad;
	} ctrl_rec_t;

	typedef union packed {
		line_rec_t line_view;
		ctrl_rec_t ctrl_view;
	} fifo_entry_u;

	// Kind bit stored beside each FIFO entry
	localparam logic KIND_LINE = 1'b0;
	localparam logic KIND_CTRL = 1'b1;

	localparam logic [`COLOR_W-1:0] DEFAULT_COLOR = '0;

	// Exchanges the two coordinates of a point for steep lines
	function automatic logic [2*`COORD_W-1:0] axis_swap(
		input logic                steep,
		input logic [`COORD_W-1:0] u,
		input logic [`COORD_W-1:0] v
	);
		axis_swap = steep ? {v, u} : {u, v};
	endfunction

endpackage

`default_nettype wire

// File: raster_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "raster_defs.svh"

module raster_top (
	input  wire                   clk,
	input  wire                   rst,
	input  wire [`COORD_W-1:0]    x0_in,
	input  wire [`COORD_W-1:0]    y0_in,
	input  wire [`COORD_W-1:0]    x1_in,
	input  wire [`COORD_W-1:0]    y1_in,
	input  wire                   valid,
	input  wire                   EoO,
	input  wire                   obj_change,
	input  wire [`COLOR_W-1:0]    bk_color,
	input  wire                   frame_ready,
	output logic                  raster_ready,
	output logic                  pixel_valid,
	output logic [`COORD_W-1:0]   frame_x,
	output logic [`FRAME_Y_W-1:0] frame_y,
	output logic [`COLOR_W-1:0]   px_color,
	output logic                  raster_done
);

	logic                      rec_valid, rec_eoo;
	logic [`COORD_W-1:0]       rx0, ry0, rx1, ry1;
	logic [`COLOR_W-1:0]       rcolor;
	logic                      wr_en, wr_kind;
	raster_pkg::fifo_entry_u   wr_entry, rd_entry;
	logic                      rd_en, rd_kind, empty, full;
	logic                      pix_valid, pix_steep;
	logic [`COORD_W-1:0]       pix_a, pix_b;
	logic [`COLOR_W-1:0]       pix_color;

	assign raster_ready = !full;

	raster_input_stage u_input (
		.clk(clk), .rst(rst),
		.x0_in(x0_in), .y0_in(y0_in), .x1_in(x1_in), .y1_in(y1_in),
		.valid(valid), .eoo(EoO), .obj_change(obj_change), .bk_color(bk_color),
		.rec_valid(rec_valid), .rec_eoo(rec_eoo),
		.rx0(rx0), .ry0(ry0), .rx1(rx1), .ry1(ry1), .rcolor(rcolor)
	);

	octant_normalizer u_norm (
		.clk(clk), .rst(rst),
		.rec_valid(rec_valid), .rec_eoo(rec_eoo),
		.rx0(rx0), .ry0(ry0), .rx1(rx1), .ry1(ry1), .rcolor(rcolor),
		.wr_en(wr_en), .wr_kind(wr_kind), .wr_entry(wr_entry)
	);

	line_fifo u_fifo (
		.clk(clk), .rst(rst),
		.wr_en(wr_en), .wr_kind(wr_kind), .wr_entry(wr_entry), .rd_en(rd_en),
		.rd_kind(rd_kind), .rd_entry(rd_entry), .empty(empty), .full(full)
	);

	bresenham_stepper u_step (
		.clk(clk), .rst(rst),
		.empty(empty), .rd_kind(rd_kind), .rd_entry(rd_entry), .frame_ready(frame_ready),
		.rd_en(rd_en), .pix_valid(pix_valid), .pix_a(pix_a), .pix_b(pix_b),
		.pix_steep(pix_steep), .pix_color(pix_color), .raster_done(raster_done)
	);

	pixel_denormalizer u_denorm (
		.pix_valid(pix_valid), .pix_a(pix_a), .pix_b(pix_b),
		.pix_steep(pix_steep), .pix_color(pix_color),
		.pixel_valid(pixel_valid), .frame_x(frame_x), .frame_y(frame_y),
		.px_color(px_color)
	);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module tb_raster -o tb_raster_sim
./obj_dir/tb_raster_sim | tee sim.log

if grep -q "^sim passed$" sim.log; then
	exit 0
else
	echo "simulation did not report a pass"
	exit 1
fi

// File: tb_raster.sv
`timescale 1ns/100ps
`default_nettype none

`include "raster_defs.svh"

module tb_raster;

	logic                   clk, rst;
	logic [`COORD_W-1:0]    x0_in, y0_in, x1_in, y1_in;
	logic                   valid, eoo, obj_change, frame_ready;
	logic [`COLOR_W-1:0]    bk_color;
	wire                    raster_ready, pixel_valid, raster_done;
	wire [`COORD_W-1:0]     frame_x;
	wire [`FRAME_Y_W-1:0]   frame_y;
	wire [`COLOR_W-1:0]     px_color;

	// Expected pixels in output order
	logic [`COORD_W-1:0]    exp_x [$];
	logic [`FRAME_Y_W-1:0]  exp_y [$];
	logic [`COLOR_W-1:0]    exp_c [$];
	logic [15:0]            lfsr = 16'd9;
	int                     cur_color = 0;
	int                     done_cnt = 0;
	int                     eoo_cnt = 0;

	raster_top u_dut (
		.clk(clk), .rst(rst),
		.x0_in(x0_in), .y0_in(y0_in), .x1_in(x1_in), .y1_in(y1_in),
		.valid(valid), .EoO(eoo), .obj_change(obj_change), .bk_color(bk_color),
		.frame_ready(frame_ready), .raster_ready(raster_ready),
		.pixel_valid(pixel_valid), .frame_x(frame_x), .frame_y(frame_y),
		.px_color(px_color), .raster_done(raster_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			stop_on_error($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
	endtask

	// Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic next_random(input int nbits, output int val);
		val = 0;
		for (int i = 0; i < nbits; i++)
		begin
			lfsr = lfsr_step(lfsr);
			val = val * 2 + int'(lfsr[0]);
		end
	endtask

	// Reference Bresenham normalized to the first octant and mapped back
	task automatic build_expected(input int x0, input int y0, input int x1, input int y1);
		int  dx, dy, sa, sb, ea, eb, t, dmaj, dmin, err, b;
		bit  steep, neg;
		dx = (x1 > x0) ? x1 - x0 : x0 - x1;
		dy = (y1 > y0) ? y1 - y0 : y0 - y1;
		steep = dy > dx;
		sa = steep ? y0 : x0;
		sb = steep ? x0 : y0;
		ea = steep ? y1 : x1;
		eb = steep ? x1 : y1;
		if (sa > ea)
		begin
			t = sa;
			sa = ea;
			ea = t;
			t = sb;
			sb = eb;
			eb = t;
		end
		neg = eb < sb;
		dmaj = ea - sa;
		dmin = neg ? sb - eb : eb - sb;
		err = dmaj / 2;
		b = sb;
		for (int a = sa; a <= ea; a++)
		begin
			exp_x.push_back(`COORD_W'(steep ? b : a));
			exp_y.push_back(`FRAME_Y_W'(steep ? a : b));
			exp_c.push_back(`COLOR_W'(cur_color));
			err = err - dmin;
			if (err < 0)
			begin
				b = neg ? b - 1 : b + 1;
				err = err + dmaj;
			end
		end
	endtask

	// Pixel collector takes a pixel when valid and ready meet
	always @(negedge clk)
	begin
		if (rst && pixel_valid && frame_ready)
		begin
			if (exp_x.size() == 0)
				stop_on_error("A pixel came out although none was expected");
			else
			begin
				compare_value("frame_x", 32'(frame_x), 32'(exp_x[0]));
				compare_value("frame_y", 32'(frame_y), 32'(exp_y[0]));
				compare_value("px_color", 32'(px_color), 32'(exp_c[0]));
				void'(exp_x.pop_front());
				void'(exp_y.pop_front());
				void'(exp_c.pop_front());
			end
		end
		if (rst && raster_done)
		begin
			compare_value("pixels_left_at_raster_done", exp_x.size(), 0);
			done_cnt++;
		end
	end

	task automatic wait_ready();
		int n;
		n = 0;
		while (!raster_ready)
		begin
			if (n >= 3000)
				stop_on_error("Timed out waiting for raster_ready to rise");
			@(posedge clk);
			#2;
			n++;
		end
	endtask

	task automatic send_line(input int x0, input int y0, input int x1, input int y1);
		wait_ready();
		build_expected(x0, y0, x1, y1);
		x0_in = `COORD_W'(x0);
		y0_in = `COORD_W'(y0);
		x1_in = `COORD_W'(x1);
		y1_in = `COORD_W'(y1);
		valid = 1'b1;
		@(posedge clk);
		#2;
		valid = 1'b0;
		// Let the full flag catch up with the entry in flight
		repeat (2)
		begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic send_eoo();
		wait_ready();
		eoo = 1'b1;
		eoo_cnt++;
		@(posedge clk);
		#2;
		eoo = 1'b0;
		repeat (2)
		begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic change_color(input int c);
		bk_color = `COLOR_W'(c);
		obj_change = 1'b1;
		cur_color = c;
		@(posedge clk);
		#2;
		obj_change = 1'b0;
	endtask

	// Runs until every expected pixel is out with an optional stalling buffer
	task automatic drain_pixels(input bit stall);
		int n;
		n = 0;
		while (exp_x.size() != 0 || pixel_valid)
		begin
			if (n >= 20000)
				stop_on_error("Timed out waiting for the expected pixels");
			@(posedge clk);
			#2;
			frame_ready = stall ? ((n % 7) >= 3) : 1'b1;
			n++;
		end
		frame_ready = 1'b1;
	endtask

	task automatic wait_done(input int target);
		int n;
		n = 0;
		while (done_cnt < target)
		begin
			if (n >= 100)
				stop_on_error("Timed out waiting for raster_done");
			@(posedge clk);
			#2;
			n++;
		end
	endtask

	task automatic horizontal_and_shallow();
		send_line(5, 10, 25, 10);
		send_line(0, 0, 30, 12);
		drain_pixels(1'b0);
	endtask

	task automatic steep_and_reversed();
		send_line(100, 50, 110, 90);
		send_line(300, 200, 250, 210);
		send_line(10, 400, 60, 380);
		send_line(200, 300, 190, 260);
		drain_pixels(1'b0);
	endtask

	// The queued line keeps the color it was sent with
	task automatic color_switch();
		change_color(5);
		send_line(40, 40, 60, 45);
		change_color(2);
		send_line(60, 45, 40, 70);
		drain_pixels(1'b0);
	endtask

	task automatic stalled_output();
		send_line(320, 240, 350, 229);
		send_line(10, 10, 14, 33);
		send_line(600, 470, 590, 470);
		drain_pixels(1'b1);
	endtask

	task automatic end_of_objects();
		send_line(1, 1, 9, 4);
		send_line(500, 100, 497, 110);
		send_eoo();
		drain_pixels(1'b0);
		wait_done(eoo_cnt);
		repeat (20) @(posedge clk);
		#2;
		compare_value("raster_done_count", done_cnt, eoo_cnt);
	endtask

	task automatic random_batch();
		int x0, y0, x1, y1;
		for (int i = 0; i < 12; i++)
		begin
			next_random(10, x0);
			next_random(9, y0);
			next_random(10, x1);
			next_random(9, y1);
			send_line(x0 % 640, y0 % 480, x1 % 640, y1 % 480);
		end
		send_eoo();
		drain_pixels(1'b0);
		wait_done(eoo_cnt);
	endtask

	initial
	begin
		rst = 1'b0;
		x0_in = '0;
		y0_in = '0;
		x1_in = '0;
		y1_in = '0;
		valid = 1'b0;
		eoo = 1'b0;
		obj_change = 1'b0;
		bk_color = '0;
		frame_ready = 1'b1;
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b1;
		compare_value("raster_ready", 32'(raster_ready), 1);
		compare_value("pixel_valid", 32'(pixel_valid), 0);
		compare_value("raster_done", 32'(raster_done), 0);
		horizontal_and_shallow();
		steep_and_reversed();
		color_switch();
		stalled_output();
		end_of_objects();
		random_batch();
		compare_value("raster_done_count", done_cnt, eoo_cnt);
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
raster_pkg.sv
raster_input_stage.sv
octant_normalizer.sv
line_fifo.sv
bresenham_stepper.sv
pixel_denormalizer.sv
raster_top.sv
tb_raster.sv
